// ==== rtl/imul_pkg.sv ====
/*
  shared types for the iterative multiplier; operand width is fixed at 32
  bits, so nothing downstream takes a width parameter
*/
package imul_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand and full product width
  localparam int OPND_W = 32;
  localparam int PROD_W = 2 * OPND_W;

  // step counter runs 0 .. OPND_W-1
  localparam int CNT_W = $clog2(OPND_W);

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------

  // one multiply request, 65 bits
  typedef struct packed {
    logic [OPND_W-1:0] a;          // multiplicand
    logic [OPND_W-1:0] b;          // multiplier
    logic              is_signed;  // both operands two's complement
  } mul_req_t;

  // one result, always the full product
  typedef struct packed {
    logic [PROD_W-1:0] product;
  } mul_resp_t;

endpackage

// ==== rtl/imul_fifo.sv ====
/*
  valid/ready FIFO; DEPTH must be a power of two, at least 2
  no bypass, so a write shows at the output one cycle later
*/
`timescale 1ns/1ps

module imul_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clk,
  input  logic reset,
  // write side
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  // read side
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------

  localparam int IDX_W = $clog2(DEPTH);
  localparam int PTR_W = IDX_W + 1;

  // entries hold payload only
  T mem [DEPTH];

  // pointers carry an extra wrap bit to tell full from empty
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] fill;

  logic full;
  logic empty;
  logic do_wr;
  logic do_rd;

  assign fill  = wr_ptr - rd_ptr;
  // same index, different wrap bit
  assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                 (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // ready looks at fill state only, never at out_ready
  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr[IDX_W-1:0]];

  assign do_wr = in_valid && in_ready;
  assign do_rd = out_valid && out_ready;

  // --------------------------------------------------
  // update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // payload write
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[IDX_W-1:0]] <= in_data;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // occupancy never exceeds DEPTH, so no write slipped in while full
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    fill <= PTR_W'(DEPTH));

  // an empty FIFO leaves its read pointer alone
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    empty |=> (rd_ptr == $past(rd_ptr)));

  // head entry holds while the reader stalls
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

// ==== rtl/imul_ctrl.sv ====
/*
  engine FSM for the shift-and-add multiplier; one operation at a time,
  32 calc cycles per operation, result held in done until taken
*/
`timescale 1ns/1ps

module imul_ctrl (
  input  logic clk,
  input  logic reset,
  // request side, from the request FIFO
  input  logic req_valid,
  output logic req_ready,
  // response side, to the response FIFO
  output logic resp_valid,
  input  logic resp_ready,
  // datapath strobes
  output logic load,
  output logic step
);

  import imul_pkg::*;

  // --------------------------------------------------
  // state
  // --------------------------------------------------

  // 2'b11 is never used
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_t;

  state_t state;
  state_t state_nxt;

  // counts calc cycles, last one is OPND_W-1
  logic [CNT_W-1:0] cnt;
  logic             cnt_last;

  logic req_xfer;
  logic resp_xfer;

  assign cnt_last = (cnt == CNT_W'(OPND_W - 1));

  // --------------------------------------------------
  // handshakes and strobes
  // --------------------------------------------------

  // ready only while idle, independent of req_valid
  assign req_ready  = (state == IDLE);
  assign resp_valid = (state == DONE);

  assign req_xfer  = req_valid && req_ready;
  assign resp_xfer = resp_valid && resp_ready;

  // operands are captured on the accepting edge
  assign load = req_xfer;
  // one shift-add per calc cycle
  assign step = (state == CALC);

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req_xfer) begin
          state_nxt = CALC;
        end
      end
      CALC: begin
        // leave after the 32nd step
        if (cnt_last) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        // hold the result until the response FIFO takes it
        if (resp_xfer) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      // counter restarts on every accepted request
      if (req_xfer) begin
        cnt <= '0;
      end else if (step) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the datapath never sees a load during calc
  a_strobes_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && step));

  // a pending result is not withdrawn
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> resp_valid);

  // unused encoding never reached
  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {IDLE, CALC, DONE});

endmodule

// ==== rtl/imul_dpath.sv ====
/*
  shift-and-add datapath on operand magnitudes; the result is only
  meaningful from the end of calc until the next load
*/
`timescale 1ns/1ps

module imul_dpath (
  input  logic                 clk,
  input  logic                 reset,
  // head request, sampled on load
  input  imul_pkg::mul_req_t   req,
  input  logic                 load,
  input  logic                 step,
  // signed-corrected product
  output imul_pkg::mul_resp_t  result
);

  import imul_pkg::*;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  logic              a_neg;
  logic              b_neg;
  logic [OPND_W-1:0] a_mag;
  logic [OPND_W-1:0] b_mag;

  // top bit only counts as a sign for signed requests
  assign a_neg = req.is_signed && req.a[OPND_W-1];
  assign b_neg = req.is_signed && req.b[OPND_W-1];

  // most negative value maps to 2**31, which fits unsigned
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  // multiplicand widened to the product width for shifting left
  logic [PROD_W-1:0] mcand;
  // multiplier, consumed from the low bit
  logic [OPND_W-1:0] mplier;
  logic [PROD_W-1:0] acc;
  // product sign, set on load
  logic              neg;

  logic [PROD_W-1:0] acc_add;

  // partial product for this step
  assign acc_add = mplier[0] ? (acc + mcand) : acc;

  // shift registers carry payload only
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{(PROD_W - OPND_W){1'b0}}, a_mag};
      mplier <= b_mag;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulator and sign
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (load) begin
      acc <= '0;
      neg <= a_neg ^ b_neg;
    end else if (step) begin
      acc <= acc_add;
    end
  end

  // --------------------------------------------------
  // output
  // --------------------------------------------------

  logic [PROD_W-1:0] prod_fix;

  // two's complement on the way out
  assign prod_fix = neg ? (~acc + 1'b1) : acc;

  assign result.product = prod_fix;

endmodule

// ==== rtl/imul_unit.sv ====
/*
  iterative 32x32 multiplier with buffered valid/ready ports
  REQ_DEPTH and RESP_DEPTH must be powers of two, at least 2
*/
`timescale 1ns/1ps

module imul_unit #(
  parameter int REQ_DEPTH  = 4,
  parameter int RESP_DEPTH = 2
) (
  input  logic                clk,
  input  logic                reset,
  // request port
  input  logic                req_valid,
  output logic                req_ready,
  input  imul_pkg::mul_req_t  req,
  // response port
  output logic                resp_valid,
  input  logic                resp_ready,
  output imul_pkg::mul_resp_t resp
);

  import imul_pkg::*;

  // --------------------------------------------------
  // internal wires
  // --------------------------------------------------

  // request FIFO head
  logic      fifo_req_valid;
  mul_req_t  q_req;
  logic      eng_req_ready;

  // engine to response FIFO
  logic      eng_resp_valid;
  logic      eng_resp_ready;
  mul_resp_t eng_result;

  // datapath strobes
  logic      load;
  logic      step;

  // --------------------------------------------------
  // request buffer
  // --------------------------------------------------

  imul_fifo #(
    .T     (mul_req_t),
    .DEPTH (REQ_DEPTH)
  ) u_req_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req),
    .out_valid (fifo_req_valid),
    .out_ready (eng_req_ready),
    .out_data  (q_req)
  );

  // --------------------------------------------------
  // engine
  // --------------------------------------------------

  imul_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (fifo_req_valid),
    .req_ready  (eng_req_ready),
    .resp_valid (eng_resp_valid),
    .resp_ready (eng_resp_ready),
    .load       (load),
    .step       (step)
  );

  // operands come straight from the FIFO head on load
  imul_dpath u_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (q_req),
    .load   (load),
    .step   (step),
    .result (eng_result)
  );

  // --------------------------------------------------
  // response buffer
  // --------------------------------------------------

  imul_fifo #(
    .T     (mul_resp_t),
    .DEPTH (RESP_DEPTH)
  ) u_resp_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (eng_resp_valid),
    .in_ready  (eng_resp_ready),
    .in_data   (eng_result),
    .out_valid (resp_valid),
    .out_ready (resp_ready),
    .out_data  (resp)
  );

endmodule

// ==== sim/imul_tb.sv ====
/*
  testbench for imul_unit; every product is checked in order against a
  reference model, and the run stops at the first mismatch
*/
`timescale 1ns/1ps

module imul_tb;

  import imul_pkg::*;

  // --------------------------------------------------
  // run length and timing
  // --------------------------------------------------

  localparam int N_SIGNED   = 6;
  localparam int N_UNSIGNED = 2;
  localparam int N_RAND     = 200;
  localparam int N_REQ      = N_SIGNED + N_UNSIGNED + 2 * N_RAND;
  localparam int CLK_NS     = 10;
  localparam int RESET_CYC  = 5;

  // one op per 34 cycles at best, x4 margin for stalls and gaps
  localparam longint WATCHDOG_NS =
    longint'(N_REQ) * 34 * CLK_NS * 4 + RESET_CYC * CLK_NS;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------

  logic      clk;
  logic      reset;
  logic      req_valid;
  logic      req_ready;
  mul_req_t  req;
  logic      resp_valid;
  logic      resp_ready;
  mul_resp_t resp;

  // scoreboard, expected products and their test names in request order
  mul_resp_t exp_q[$];
  string     name_q[$];

  // test 5 controls
  logic rand_resp;
  logic stall_test;
  logic saw_full;
  // cycles left before the consumer picks a new ready level
  int   run_left;

  imul_unit #(
    .REQ_DEPTH  (4),
    .RESP_DEPTH (2)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  // 10 ns period
  initial clk = 1'b0;
  always #5 clk = ~clk;

  // --------------------------------------------------
  // reference model and compares
  // --------------------------------------------------

  // full product, operands sign- or zero-extended to 64 bits first
  function automatic mul_resp_t ref_mul(mul_req_t r);
    logic signed [PROD_W-1:0] sa;
    logic signed [PROD_W-1:0] sb;
    mul_resp_t                res;
    if (r.is_signed) begin
      sa = {{OPND_W{r.a[OPND_W-1]}}, r.a};
      sb = {{OPND_W{r.b[OPND_W-1]}}, r.b};
    end else begin
      sa = {{OPND_W{1'b0}}, r.a};
      sb = {{OPND_W{1'b0}}, r.b};
    end
    // low 64 bits of the wide product are exact for both modes
    res.product = sa * sb;
    return res;
  endfunction

  task automatic check_resp(string name, mul_resp_t exp, mul_resp_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp.product, act.product);
      $display("Test FAILED");
      $fatal(1, "product mismatch, stopping at first error");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "handshake level mismatch, stopping at first error");
    end
  endtask

  // --------------------------------------------------
  // monitors
  // --------------------------------------------------

  // pop one expected entry per response transfer
  always @(posedge clk) begin
    if (!reset && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        $display("a response arrived while no request was outstanding, product %h",
                 resp.product);
        $display("Test FAILED");
        $fatal(1, "unexpected response");
      end else begin
        check_resp(name_q.pop_front(), exp_q.pop_front(), resp);
      end
    end
  end

  // request FIFO full seen at least once under back-pressure
  always @(posedge clk) begin
    if (stall_test && !req_ready) begin
      saw_full <= 1'b1;
    end
  end

  // consumer side, random stalls only during test 5
  // runs of one level last up to 160 cycles, so a low run outlasts several
  // 34-cycle operations, fills the response FIFO and holds the engine in done
  always @(negedge clk) begin
    if (rand_resp) begin
      if (run_left == 0) begin
        resp_ready = ($urandom_range(0, 1) == 1);
        run_left   = $urandom_range(1, 160);
      end
      run_left = run_left - 1;
    end else begin
      resp_ready = 1'b1;
      run_left   = 0;
    end
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: responses stopped arriving, %0d still outstanding",
             exp_q.size());
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------
  // stimulus helpers, all called on a falling edge
  // --------------------------------------------------

  // hold valid until ready, then leave at the falling edge after the transfer
  task automatic send(mul_req_t r, string name);
    req_valid = 1'b1;
    req       = r;
    // ready only depends on FIFO state, so it is stable until the rising edge
    while (!req_ready) begin
      @(negedge clk);
    end
    exp_q.push_back(ref_mul(r));
    name_q.push_back(name);
    @(negedge clk);
  endtask

  task automatic send_op(logic [OPND_W-1:0] a, logic [OPND_W-1:0] b,
                         logic is_signed, string name);
    mul_req_t r;
    r.a         = a;
    r.b         = b;
    r.is_signed = is_signed;
    send(r, name);
  endtask

  function automatic mul_req_t rand_req();
    mul_req_t r;
    r.a         = $urandom();
    r.b         = $urandom();
    r.is_signed = $urandom_range(0, 1);
    return r;
  endfunction

  // drop valid for n cycles
  task automatic idle(int n);
    req_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // wait until every outstanding result has been compared
  task automatic drain();
    req_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h254));
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    rand_resp  = 1'b0;
    stall_test = 1'b0;
    saw_full   = 1'b0;
    run_left   = 0;
    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;

    // 1: idle levels straight out of reset
    check_bit("reset resp_valid", 1'b0, resp_valid);
    check_bit("reset req_ready", 1'b1, req_ready);

    // 2: signed corners
    send_op(32'h0000_0000, 32'h8765_4321, 1'b1, "signed 0*x");
    send_op(32'hffff_ffff, 32'hffff_ffff, 1'b1, "signed -1*-1");
    send_op(32'hffff_ffff, 32'h0000_0001, 1'b1, "signed -1*1");
    send_op(32'h8000_0000, 32'h8000_0000, 1'b1, "signed min*min");
    send_op(32'h8000_0000, 32'hffff_ffff, 1'b1, "signed min*-1");
    send_op(32'h7fff_ffff, 32'h8000_0000, 1'b1, "signed max*min");
    drain();

    // 3: unsigned corners, zero-extended
    send_op(32'hffff_ffff, 32'hffff_ffff, 1'b0, "unsigned max*max");
    send_op(32'hffff_ffff, 32'h0000_0001, 1'b0, "unsigned max*1");
    drain();

    // 4: back-to-back random
    for (int i = 0; i < N_RAND; i++) begin
      send(rand_req(), $sformatf("b2b random #%0d", i));
    end
    drain();

    // 5: random gaps with a stalling consumer
    rand_resp  = 1'b1;
    stall_test = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      send(rand_req(), $sformatf("stall random #%0d", i));
      idle($urandom_range(0, 3));
    end
    drain();
    rand_resp  = 1'b0;
    stall_test = 1'b0;
    check_bit("req_ready low under back-pressure", 1'b1, saw_full);

    // unit back to idle with nothing left inside
    repeat (2) @(negedge clk);
    check_bit("final resp_valid", 1'b0, resp_valid);
    check_bit("final req_ready", 1'b1, req_ready);

    $display("Test OK");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/imul_pkg.sv
rtl/imul_fifo.sv
rtl/imul_ctrl.sv
rtl/imul_dpath.sv
rtl/imul_unit.sv
sim/imul_tb.sv
